// File: sim.f
+incdir+verilog
verilog/video_pkg.sv
verilog/edge_detect.sv
verilog/pixel_capture.sv
verilog/frame_buffer.sv
verilog/ram2video.sv
verilog/video_top.sv
verif/video_tb.sv

// File: verif/video_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_consts.svh"

module video_tb;

    localparam int NUM_TESTS = 5;
    localparam int CLOCK_PERIOD = 100;
    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int START_LIMIT = 300;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (300 + 3 * FRAME_CYCLES) * 2;

    logic                  clock;
    logic                  combined_reset;
    video_pkg::pixel_t     in_pixel;
    logic                  in_valid;
    logic                  in_frame_start;
    logic                  line_doubler;
    logic                  scanline_enable;
    video_pkg::intensity_t scanline_intensity;
    logic                  enable_osd;
    video_pkg::pixel_t     video_out;
    logic                  hsync;
    logic                  vsync;
    logic                  draw_area;

    // stimulus table, one row per test
    string tab_name      [NUM_TESTS];
    bit    tab_doubler   [NUM_TESTS];
    bit    tab_scan      [NUM_TESTS];
    int    tab_intensity [NUM_TESTS];
    bit    tab_osd       [NUM_TESTS];

    video_pkg::pixel_t pixels [`BUF_WORDS];
    string cur_name;
    int    seed;
    int    test_errors;
    int    clean_tests;
    int    failed_tests;

    video_top DUT (
        .clock              (clock),
        .combined_reset     (combined_reset),
        .in_pixel           (in_pixel),
        .in_valid           (in_valid),
        .in_frame_start     (in_frame_start),
        .line_doubler       (line_doubler),
        .scanline_enable    (scanline_enable),
        .scanline_intensity (scanline_intensity),
        .enable_osd         (enable_osd),
        .video_out          (video_out),
        .hsync              (hsync),
        .vsync              (vsync),
        .draw_area          (draw_area)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("timeout: the run took longer than the tests can need and was stopped");
        $display("Testbench failed");
        $finish;
    end

    task automatic set_row(input int idx, input string name, input bit dbl, input bit scan,
                           input int intensity, input bit osd);
        tab_name[idx] = name;
        tab_doubler[idx] = dbl;
        tab_scan[idx] = scan;
        tab_intensity[idx] = intensity;
        tab_osd[idx] = osd;
    endtask

    task automatic load_table();
        set_row(0, "plain", 1'b0, 1'b0, 0, 1'b0);
        set_row(1, "doubler", 1'b1, 1'b0, 0, 1'b0);
        set_row(2, "scanline_128", 1'b0, 1'b1, 128, 1'b0);
        set_row(3, "scanline_200_osd", 1'b0, 1'b1, 200, 1'b1);
        set_row(4, "osd_only", 1'b0, 1'b0, 0, 1'b1);
    endtask

    task automatic show_mismatch(input string what, input string expected, input string actual);
        test_errors++;
        $display("FAILED %s: %s expected %s actual %s", cur_name, what, expected, actual);
    endtask

    task automatic note_problem(input string msg);
        test_errors++;
        $display("error in %s: %s", cur_name, msg);
    endtask

    // reference model for one visible output pixel
    function automatic video_pkg::pixel_t expected_pixel(input int col, input int row);
        int                line;
        int                factor;
        int                chan;
        bit                scan_row;
        bit                osd_area;
        video_pkg::pixel_t src;
        video_pkg::pixel_t result;
        line = line_doubler ? row / 2 : row;
        src = pixels[line * `BUF_LINE_LENGTH + col];
        scan_row = scanline_enable && (line_doubler ? ((row / 2) % 2 == 1) : (row % 2 == 1));
        osd_area = enable_osd && col >= `OSD_X_START && col < `OSD_X_END
            && row >= `OSD_Y_START && row < `OSD_Y_END;
        if (osd_area) begin
            factor = scan_row ? (`OSD_ALPHA * scanline_intensity) / 256 : `OSD_ALPHA;
        end else begin
            factor = scan_row ? scanline_intensity : 256;
        end
        for (int ch = 0; ch < 3; ch++) begin
            chan = src[8 * ch +: 8];
            result[8 * ch +: 8] = (chan * factor) / 256;
        end
        return result;
    endfunction

    task automatic check_idle();
        if (draw_area !== 1'b0 || video_out !== '0 || hsync !== 1'b1 || vsync !== 1'b1) begin
            show_mismatch("idle outputs", "d0 v000000 hs1 vs1",
                $sformatf("d%b v%06h hs%b vs%b", draw_area, video_out, hsync, vsync));
        end
    endtask

    task automatic stream_pixels();
        for (int i = 0; i < `BUF_WORDS; i++) begin
            @(negedge clock);
            // the generator cannot start before line 0 is stored
            if (i < `BUF_LINE_LENGTH) begin
                check_idle();
            end
            pixels[i] = video_pkg::pixel_t'($random(seed));
            in_pixel = pixels[i];
            in_valid = 1'b1;
            in_frame_start = (i == 0);
        end
        @(negedge clock);
        in_valid = 1'b0;
        in_frame_start = 1'b0;
    endtask

    task automatic capture_frame();
        int                wait_cycles;
        int                col;
        int                row;
        int                draws;
        int                hs_low;
        int                vs_low;
        int                vs_first;
        int                vs_last;
        bit                prev_draw;
        video_pkg::pixel_t exp_pix;
        wait_cycles = 0;
        @(negedge clock);
        while (draw_area !== 1'b1 && wait_cycles < START_LIMIT) begin
            @(negedge clock);
            wait_cycles++;
        end
        if (draw_area !== 1'b1) begin
            note_problem("draw_area never went high after the pixels were written");
            return;
        end
        col = 0;
        row = 0;
        draws = 0;
        hs_low = 0;
        vs_low = 0;
        vs_first = -1;
        vs_last = -1;
        prev_draw = 1'b0;
        for (int cycle = 0; cycle < FRAME_CYCLES; cycle++) begin
            if (cycle > 0) begin
                @(negedge clock);
            end
            if (draw_area === 1'b1) begin
                if (!prev_draw && row > 0) begin
                    if (hs_low != `H_SYNC_WIDTH) begin
                        show_mismatch($sformatf("hsync low cycles before row %0d", row),
                            $sformatf("%0d", `H_SYNC_WIDTH), $sformatf("%0d", hs_low));
                    end
                    hs_low = 0;
                end
                if (row < `V_VISIBLE) begin
                    exp_pix = expected_pixel(col, row);
                    if (video_out !== exp_pix) begin
                        show_mismatch($sformatf("pixel x=%0d y=%0d", col, row),
                            $sformatf("%06h", exp_pix), $sformatf("%06h", video_out));
                    end
                end
                draws++;
                col++;
                if (col == `H_VISIBLE) begin
                    col = 0;
                    row++;
                end
            end
            if (hsync === 1'b0) begin
                hs_low++;
            end
            if (vsync === 1'b0) begin
                if (vs_first < 0) begin
                    vs_first = cycle;
                    if (row != `V_VISIBLE) begin
                        note_problem("vsync went low before the last visible row was drawn");
                    end
                end
                vs_last = cycle;
                vs_low++;
            end
            prev_draw = (draw_area === 1'b1);
        end
        if (draws != `H_VISIBLE * `V_VISIBLE) begin
            show_mismatch("draw_area cycles per frame", $sformatf("%0d", `H_VISIBLE * `V_VISIBLE),
                $sformatf("%0d", draws));
        end
        if (vs_low != `V_SYNC_WIDTH * `H_TOTAL) begin
            show_mismatch("vsync low cycles", $sformatf("%0d", `V_SYNC_WIDTH * `H_TOTAL),
                $sformatf("%0d", vs_low));
        end else if (vs_last - vs_first + 1 != vs_low) begin
            note_problem("vsync low period was not one continuous stretch");
        end
    endtask

    initial begin
        combined_reset = 1'b1;
        in_pixel = '0;
        in_valid = 1'b0;
        in_frame_start = 1'b0;
        line_doubler = 1'b0;
        scanline_enable = 1'b0;
        scanline_intensity = '0;
        enable_osd = 1'b0;
        seed = 93696;
        clean_tests = 0;
        failed_tests = 0;
        load_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(negedge clock);
            cur_name = tab_name[t];
            test_errors = 0;
            line_doubler = tab_doubler[t];
            scanline_enable = tab_scan[t];
            scanline_intensity = video_pkg::intensity_t'(tab_intensity[t]);
            enable_osd = tab_osd[t];
            combined_reset = 1'b1;
            repeat (8) @(negedge clock);
            combined_reset = 1'b0;
            fork
                stream_pixels();
                capture_frame();
            join
            if (test_errors == 0) begin
                clean_tests++;
                $display("PASS %s", cur_name);
            end else begin
                failed_tests++;
                $display("FAILED %s with %0d errors", cur_name, test_errors);
            end
        end
        $display("tests run %0d, clean %0d, with errors %0d", NUM_TESTS, clean_tests,
            failed_tests);
        if (failed_tests == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/edge_detect.sv
`timescale 1ns/1ps
`default_nettype none

module edge_detect (
    input  wire logic clock,
    input  wire logic async_sig,
    output logic      rise,
    output logic      fall
);

    logic sync_meta;
    logic sync_stable;
    logic sync_prev;

    // two flop synchronizer plus one stage of history
    always_ff @(posedge clock) begin
        sync_meta   <= async_sig;
        sync_stable <= sync_meta;
        sync_prev   <= sync_stable;
    end

    assign rise = sync_stable & ~sync_prev;
    assign fall = ~sync_stable & sync_prev;

endmodule

`default_nettype wire

// File: verilog/frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_consts.svh"

module frame_buffer (
    input  wire logic                 clock,
    input  wire logic                 wr_en,
    input  wire video_pkg::buf_addr_t wr_addr,
    input  wire video_pkg::pixel_t    wr_data,
    input  wire video_pkg::buf_addr_t rd_addr,
    output video_pkg::pixel_t         rd_data
);

    video_pkg::pixel_t mem [`BUF_WORDS];

    // tracks which words hold data, only for the read check
    logic [`BUF_WORDS-1:0] word_written = '0;

    // read before write on a shared address
    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

    always_ff @(posedge clock) begin
        if (wr_en) begin
            word_written[wr_addr] <= 1'b1;
        end
    end

    a_read_known: assert property (
        @(posedge clock)
        word_written[rd_addr] |=> !$isunknown(rd_data)
    );

endmodule

`default_nettype wire

// File: verilog/pixel_capture.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_consts.svh"

module pixel_capture (
    input  wire logic              clock,
    input  wire logic              combined_reset,
    input  wire video_pkg::pixel_t in_pixel,
    input  wire logic              in_valid,
    input  wire logic              in_frame_start,
    output logic                   wr_en,
    output video_pkg::buf_addr_t   wr_addr,
    output video_pkg::pixel_t      wr_data,
    output logic                   start_trigger
);

    // one bit wider than the address so it can stop at BUF_WORDS
    logic [8:0] wr_count;
    logic       trigger_sent;
    logic       line_done;
    logic       accept;

    assign accept = in_valid && (in_frame_start || wr_count < `BUF_WORDS);

    always_ff @(posedge clock) begin
        if (combined_reset) begin
            wr_count      <= '0;
            wr_en         <= 1'b0;
            trigger_sent  <= 1'b0;
            line_done     <= 1'b0;
            start_trigger <= 1'b0;
        end else begin
            wr_en     <= accept;
            line_done <= 1'b0;
            // line_done marks the cycle the last pixel of line 0 is in the ram
            start_trigger <= line_done;
            if (accept) begin
                if (in_frame_start) begin
                    wr_count     <= 9'd1;
                    trigger_sent <= 1'b0;
                end else begin
                    wr_count <= wr_count + 1'b1;
                    if (wr_count == `BUF_LINE_LENGTH - 1 && !trigger_sent) begin
                        line_done    <= 1'b1;
                        trigger_sent <= 1'b1;
                    end
                end
            end
        end
    end

    // write port payload
    always_ff @(posedge clock) begin
        if (accept) begin
            wr_addr <= in_frame_start ? '0 : video_pkg::buf_addr_t'(wr_count);
            wr_data <= in_pixel;
        end
    end

    // a full buffer stays untouched until the next frame start
    a_no_write_past_end: assert property (
        @(posedge clock) disable iff (combined_reset)
        (wr_count == `BUF_WORDS) |=> (!wr_en || wr_addr == '0)
    );

endmodule

`default_nettype wire

// File: verilog/ram2video.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_consts.svh"

module ram2video (
    input  wire logic                  clock,
    input  wire logic                  combined_reset,
    input  wire logic                  ld_rise,
    input  wire logic                  ld_fall,
    input  wire logic                  start_trigger,
    input  wire logic                  line_doubler,
    input  wire logic                  scanline_enable,
    input  wire video_pkg::intensity_t scanline_intensity,
    input  wire logic                  enable_osd,
    output video_pkg::buf_addr_t       rd_addr,
    input  wire video_pkg::pixel_t     rd_data,
    output video_pkg::pixel_t          video_out,
    output logic                       hsync,
    output logic                       vsync,
    output logic                       draw_area
);

    localparam int UNITY = 256;

    video_pkg::gen_state_t state;
    video_pkg::coord_t     x;
    video_pkg::coord_t     y;
    video_pkg::coord_t     x_d1;
    video_pkg::coord_t     y_d1;
    video_pkg::coord_t     x_d2;
    video_pkg::coord_t     y_d2;
    video_pkg::coord_t     line_sel;
    video_pkg::buf_addr_t  addr_next;
    video_pkg::intensity_t osd_scan_factor;
    video_pkg::intensity_t factor;

    logic restart;
    logic run_d1;
    logic run_d2;
    logic in_draw;
    logic in_osd;
    logic on_scanline;
    logic in_hsync;
    logic in_vsync;

    function automatic video_pkg::pixel_t scale_pixel(
        input video_pkg::pixel_t     p,
        input video_pkg::intensity_t f
    );
        logic [16:0] r_prod;
        logic [16:0] g_prod;
        logic [16:0] b_prod;
        r_prod = p[23:16] * f;
        g_prod = p[15:8] * f;
        b_prod = p[7:0] * f;
        return {r_prod[15:8], g_prod[15:8], b_prod[15:8]};
    endfunction

    // any doubler change reruns the whole start sequence
    assign restart = combined_reset | ld_rise | ld_fall;

    always_ff @(posedge clock) begin
        if (restart) begin
            state <= video_pkg::GEN_WAIT;
            x     <= '0;
            y     <= '0;
        end else if (state == video_pkg::GEN_WAIT) begin
            if (start_trigger) begin
                state <= video_pkg::GEN_RUN;
            end
        end else begin
            if (x == `H_TOTAL - 1) begin
                x <= '0;
                if (y == `V_TOTAL - 1) begin
                    y <= '0;
                end else begin
                    y <= y + 1'b1;
                end
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // each buffer line is shown twice with the doubler on
    always_comb begin
        line_sel = line_doubler ? (y >> 1) : y;
        if (x < `H_VISIBLE && y < `V_VISIBLE) begin
            addr_next = video_pkg::buf_addr_t'(`BUF_LINE_LENGTH * line_sel + x);
        end else begin
            addr_next = '0;
        end
    end

    // stage 1 presents the address, stage 2 has the ram data
    always_ff @(posedge clock) begin
        rd_addr <= addr_next;
        x_d1    <= x;
        y_d1    <= y;
        x_d2    <= x_d1;
        y_d2    <= y_d1;
    end

    always_ff @(posedge clock) begin
        if (restart) begin
            run_d1 <= 1'b0;
            run_d2 <= 1'b0;
        end else begin
            run_d1 <= (state == video_pkg::GEN_RUN);
            run_d2 <= run_d1;
        end
    end

    always_comb begin
        in_draw = x_d2 < `H_VISIBLE && y_d2 < `V_VISIBLE;
        in_osd = enable_osd
            && x_d2 >= `OSD_X_START && x_d2 < `OSD_X_END
            && y_d2 >= `OSD_Y_START && y_d2 < `OSD_Y_END;
        on_scanline = scanline_enable && (line_doubler ? y_d2[1] : y_d2[0]);
        in_hsync = x_d2 >= `H_SYNC_START && x_d2 < `H_SYNC_START + `H_SYNC_WIDTH;
        in_vsync = y_d2 >= `V_SYNC_START && y_d2 < `V_SYNC_START + `V_SYNC_WIDTH;
        osd_scan_factor = video_pkg::intensity_t'((`OSD_ALPHA * scanline_intensity) >> 8);
        if (in_osd) begin
            factor = on_scanline ? osd_scan_factor : video_pkg::intensity_t'(`OSD_ALPHA);
        end else begin
            factor = on_scanline ? scanline_intensity : video_pkg::intensity_t'(UNITY);
        end
    end

    // syncs are active low
    always_ff @(posedge clock) begin
        if (restart || !run_d2) begin
            video_out <= '0;
            draw_area <= 1'b0;
            hsync     <= 1'b1;
            vsync     <= 1'b1;
        end else begin
            video_out <= in_draw ? scale_pixel(rd_data, factor) : '0;
            draw_area <= in_draw;
            hsync     <= !in_hsync;
            vsync     <= !in_vsync;
        end
    end

    // hsync low must match the counter position OUT_LATENCY cycles back
    a_hsync_window: assert property (
        @(posedge clock) disable iff (combined_reset)
        !hsync |-> ($past(x, `OUT_LATENCY) >= `H_SYNC_START
                    && $past(x, `OUT_LATENCY) < `H_SYNC_START + `H_SYNC_WIDTH)
    );

    a_no_draw_waiting: assert property (
        @(posedge clock) disable iff (combined_reset)
        (state == video_pkg::GEN_WAIT) |-> !draw_area
    );

endmodule

`default_nettype wire

// File: verilog/video_consts.svh
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// horizontal raster in clock cycles per line
`define H_VISIBLE       16
`define H_TOTAL         24
`define H_SYNC_START    18
`define H_SYNC_WIDTH    3

// vertical raster in lines per frame
`define V_VISIBLE       16
`define V_TOTAL         20
`define V_SYNC_START    17
`define V_SYNC_WIDTH    2

// frame buffer geometry
`define BUF_LINE_LENGTH 16
`define BUF_WORDS       256

// osd background rectangle, end is exclusive
`define OSD_X_START     4
`define OSD_X_END       12
`define OSD_Y_START     4
`define OSD_Y_END       12

// osd background dimming in 256ths
`define OSD_ALPHA       64

// counters to video_out: address reg, ram read, output reg
`define OUT_LATENCY     3

`endif

// File: verilog/video_pkg.sv
`default_nettype none

package video_pkg;

    // red in [23:16], green in [15:8], blue in [7:0]
    typedef logic [23:0] pixel_t;

    // word address into the frame buffer
    typedef logic [7:0] buf_addr_t;

    // raster counter for x or y
    typedef logic [5:0] coord_t;

    // multiplier in 256ths, 256 passes the channel through
    typedef logic [8:0] intensity_t;

    // video generator control
    typedef enum logic {
        GEN_WAIT,
        GEN_RUN
    } gen_state_t;

endpackage

`default_nettype wire

// File: verilog/video_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_top (
    input  wire logic                  clock,
    input  wire logic                  combined_reset,
    input  wire video_pkg::pixel_t     in_pixel,
    input  wire logic                  in_valid,
    input  wire logic                  in_frame_start,
    input  wire logic                  line_doubler,
    input  wire logic                  scanline_enable,
    input  wire video_pkg::intensity_t scanline_intensity,
    input  wire logic                  enable_osd,
    output video_pkg::pixel_t          video_out,
    output logic                       hsync,
    output logic                       vsync,
    output logic                       draw_area
);

    video_pkg::buf_addr_t wr_addr;
    video_pkg::buf_addr_t rd_addr;
    video_pkg::pixel_t    wr_data;
    video_pkg::pixel_t    rd_data;
    logic                 wr_en;
    logic                 start_trigger;
    logic                 ld_rise;
    logic                 ld_fall;

    edge_detect u_ld_edge (
        .clock     (clock),
        .async_sig (line_doubler),
        .rise      (ld_rise),
        .fall      (ld_fall)
    );

    pixel_capture u_capture (
        .clock          (clock),
        .combined_reset (combined_reset),
        .in_pixel       (in_pixel),
        .in_valid       (in_valid),
        .in_frame_start (in_frame_start),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .start_trigger  (start_trigger)
    );

    frame_buffer u_buffer (
        .clock   (clock),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    ram2video u_video (
        .clock              (clock),
        .combined_reset     (combined_reset),
        .ld_rise            (ld_rise),
        .ld_fall            (ld_fall),
        .start_trigger      (start_trigger),
        .line_doubler       (line_doubler),
        .scanline_enable    (scanline_enable),
        .scanline_intensity (scanline_intensity),
        .enable_osd         (enable_osd),
        .rd_addr            (rd_addr),
        .rd_data            (rd_data),
        .video_out          (video_out),
        .hsync              (hsync),
        .vsync              (vsync),
        .draw_area          (draw_area)
    );

endmodule

`default_nettype wire
